// ==== Makefile ====
# Verilator build and run for the DVI pixel output subsystem

VERILATOR  ?= verilator
TOP        ?= tb_dvi_top
FILELIST   ?= dvi_out.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
TIMESCALE  ?= 1ns/100ps
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= -Wall

SRCS := $(shell grep -v '^+' $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) -f $(FILELIST) \
		--top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "Finished with no errors" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --timescale $(TIMESCALE) \
		-f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dvi_out.f ====
hw/dvi_pkg.sv
hw/dvi_if.sv
hw/sync_gen.sv
hw/plane_fetch.sv
hw/pixel_out.sv
hw/dvi_top.sv
test/tb_clock_gen.sv
test/tb_checker.sv
test/tb_dvi_top.sv

// ==== hw/dvi_if.sv ====
//////////////////////////////
// raster timing bundle
//////////////////////////////

// decoded raster position from the sync generator
interface raster_if;

   // active high syncs
   logic hsync;
   logic vsync;
   // inside the visible window
   logic active;
   // strobe on pixel (0, 0) of each frame
   logic frame_start;

   // timing source
   modport src (
      output hsync,
      output vsync,
      output active,
      output frame_start
   );

   // timing consumer
   modport dst (
      input  hsync,
      input  vsync,
      input  active,
      input  frame_start
   );

endinterface

//////////////////////////////
// prefetch queue bundle
//////////////////////////////

// head of the queue plus pop, no back-pressure on pop
interface pixel_queue_if import dvi_pkg::*; ();

   // head entry, valid while empty is low
   logic [pix_w-1:0] data;
   logic             empty;
   // consumes head at the clock edge
   logic             pop;
   // consumer lost the stream, fetcher must resync
   logic             underflow_seen;

   // queue owner side
   modport src (
      output data,
      output empty,
      input  pop,
      input  underflow_seen
   );

   // pixel consumer side
   modport dst (
      input  data,
      input  empty,
      output pop,
      output underflow_seen
   );

endinterface

// ==== hw/dvi_pkg.sv ====
package dvi_pkg;

   //////////////////////////////
   // pixel format
   //////////////////////////////

   // one 24-bit rgb word per pixel clock
   localparam int pix_w = 24;

   //////////////////////////////
   // horizontal raster
   //////////////////////////////

   // small test raster, widths in pixel clocks
   localparam int h_active = 16;
   localparam int h_front  = 2;
   localparam int h_sync   = 3;
   localparam int h_back   = 3;
   localparam int h_total  = h_active + h_front + h_sync + h_back;
   localparam int h_cnt_w  = $clog2(h_total);

   //////////////////////////////
   // vertical raster
   //////////////////////////////

   // heights in lines
   localparam int v_active = 8;
   localparam int v_front  = 1;
   localparam int v_sync   = 2;
   localparam int v_back   = 2;
   localparam int v_total  = v_active + v_front + v_sync + v_back;
   localparam int v_cnt_w  = $clog2(v_total);

   //////////////////////////////
   // frame buffer and queue
   //////////////////////////////

   // one word per visible pixel
   localparam int fb_words  = h_active * v_active;
   localparam int fb_addr_w = $clog2(fb_words);

   // prefetch queue sizing
   localparam int queue_depth = 8;
   localparam int q_ptr_w     = $clog2(queue_depth);
   // occupancy has to reach queue_depth itself
   localparam int q_cnt_w     = $clog2(queue_depth + 1);

   // fetcher states
   typedef enum logic [1:0] {
      fetch_idle,
      fetch_run,
      fetch_hold
   } fetch_state_t;

endpackage

// ==== hw/dvi_top.sv ====
module dvi_top import dvi_pkg::*; (
   input  logic                 dvi_clk,
   input  logic                 rst,
   // frame buffer read port
   output logic [fb_addr_w-1:0] rom_addr,
   input  logic [pix_w-1:0]     rom_data,
   // pixel port
   output logic [pix_w-1:0]     d,
   output logic                 hsync,
   output logic                 vsync,
   output logic                 blank,
   // sticky starvation flag
   output logic                 underflow
);

   //////////////////////////////
   // internal bundles
   //////////////////////////////

   // sync_gen to pixel_out
   raster_if      rs_if ();
   // plane_fetch to pixel_out
   pixel_queue_if q_if ();

   //////////////////////////////
   // blocks
   //////////////////////////////

   // raster counters
   sync_gen sync_gen_inst (
      .dvi_clk (dvi_clk),
      .rst     (rst),
      .rs      (rs_if.src)
   );

   // frame-buffer prefetch, restarts on frame start after a slip
   plane_fetch plane_fetch_inst (
      .dvi_clk     (dvi_clk),
      .rst         (rst),
      .frame_start (rs_if.frame_start),
      .rom_addr    (rom_addr),
      .rom_data    (rom_data),
      .q           (q_if.src)
   );

   // combines raster and pixels, one cycle behind the counters
   pixel_out pixel_out_inst (
      .dvi_clk   (dvi_clk),
      .rst       (rst),
      .rs        (rs_if.dst),
      .q         (q_if.dst),
      .d         (d),
      .hsync     (hsync),
      .vsync     (vsync),
      .blank     (blank),
      .underflow (underflow)
   );

endmodule

// ==== hw/pixel_out.sv ====
module pixel_out import dvi_pkg::*; (
   input  logic             dvi_clk,
   input  logic             rst,
   raster_if.dst            rs,
   pixel_queue_if.dst       q,
   output logic [pix_w-1:0] d,
   output logic             hsync,
   output logic             vsync,
   output logic             blank,
   output logic             underflow
);

   // stream lost until a frame start with data queued
   logic slipped;

   //////////////////////////////
   // pop and underflow decode
   //////////////////////////////

   // one word per visible pixel
   // only a frame start with data restarts the stream after a slip
   assign q.pop = rs.active && !q.empty && (!slipped || rs.frame_start);

   // first starved pixel tells the fetcher to resync
   assign q.underflow_seen = rs.active && q.empty && !slipped;

   //////////////////////////////
   // output registers
   //////////////////////////////

   always_ff @(posedge dvi_clk or posedge rst) begin
      if (rst) begin
         d         <= '0;
         hsync     <= 1'b0;
         vsync     <= 1'b0;
         blank     <= 1'b1;
         underflow <= 1'b0;
         slipped   <= 1'b0;
      end else begin
         // syncs delayed to line up with d
         hsync <= rs.hsync;
         vsync <= rs.vsync;
         blank <= !rs.active;
         // zero outside active video and on starved pixels
         if (q.pop) begin
            d <= q.data;
         end else begin
            d <= '0;
         end
         // sticky until reset
         if (q.underflow_seen) underflow <= 1'b1;
         // slip state
         if (q.underflow_seen) begin
            slipped <= 1'b1;
         end else if (q.pop) begin
            slipped <= 1'b0;
         end
      end
   end

   // restart after a slip expects the frame start strobe inside active video
   a_frame_start_active: assert property (@(posedge dvi_clk) disable iff (rst)
      rs.frame_start |-> rs.active);

endmodule

// ==== hw/plane_fetch.sv ====
module plane_fetch import dvi_pkg::*; (
   input  logic                 dvi_clk,
   input  logic                 rst,
   input  logic                 frame_start,
   output logic [fb_addr_w-1:0] rom_addr,
   input  logic [pix_w-1:0]     rom_data,
   pixel_queue_if.src           q
);

   // circular pointer advance
   function automatic logic [q_ptr_w-1:0] ptr_inc(input logic [q_ptr_w-1:0] p);
      if (p == q_ptr_w'(queue_depth - 1)) begin
         return '0;
      end
      return p + 1'b1;
   endfunction

   fetch_state_t         state;
   fetch_state_t         state_nxt;
   // reads issued but not yet popped
   logic [q_cnt_w-1:0]   credit_used;
   logic                 credit_ok;
   logic                 issue;
   // memory return strobe one cycle behind the address
   logic                 rd_vld;
   logic                 wr_en;

   // queue storage and bookkeeping
   logic [pix_w-1:0]     mem [queue_depth];
   logic [q_ptr_w-1:0]   wr_ptr;
   logic [q_ptr_w-1:0]   rd_ptr;
   logic [q_cnt_w-1:0]   count;

   //////////////////////////////
   // fetch control
   //////////////////////////////

   // room for one more read counting those in flight
   assign credit_ok = (credit_used < q_cnt_w'(queue_depth));
   assign issue     = (state == fetch_run) && credit_ok;

   always_comb begin
      state_nxt = state;
      case (state)
         fetch_idle: begin
            // resync only at a frame boundary
            if (frame_start) state_nxt = fetch_run;
         end
         fetch_run: begin
            if (q.underflow_seen)  state_nxt = fetch_idle;
            else if (!credit_ok)   state_nxt = fetch_hold;
         end
         fetch_hold: begin
            if (q.underflow_seen)  state_nxt = fetch_idle;
            else if (credit_ok)    state_nxt = fetch_run;
         end
         default: state_nxt = fetch_idle;
      endcase
   end

   always_ff @(posedge dvi_clk or posedge rst) begin
      if (rst) begin
         state    <= fetch_run;
         rom_addr <= '0;
         rd_vld   <= 1'b0;
      end else begin
         state  <= state_nxt;
         // reads in flight are dropped while idle
         rd_vld <= issue;
         if (state == fetch_idle) begin
            if (frame_start) rom_addr <= '0;
         end else if (issue) begin
            // sequential walk with wrap at end of frame
            if (rom_addr == fb_addr_w'(fb_words - 1)) begin
               rom_addr <= '0;
            end else begin
               rom_addr <= rom_addr + 1'b1;
            end
         end
      end
   end

   //////////////////////////////
   // prefetch queue
   //////////////////////////////

   assign wr_en = rd_vld && (state != fetch_idle);

   // queue payload
   always_ff @(posedge dvi_clk) begin
      if (wr_en) mem[wr_ptr] <= rom_data;
   end

   always_ff @(posedge dvi_clk or posedge rst) begin
      if (rst) begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         count       <= '0;
         credit_used <= '0;
      end else if (state == fetch_idle) begin
         // flushed while waiting for frame start
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         count       <= '0;
         credit_used <= '0;
      end else begin
         if (wr_en)  wr_ptr <= ptr_inc(wr_ptr);
         if (q.pop)  rd_ptr <= ptr_inc(rd_ptr);
         // occupancy
         case ({wr_en, q.pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         // credits return on pop
         case ({issue, q.pop})
            2'b10:   credit_used <= credit_used + 1'b1;
            2'b01:   credit_used <= credit_used - 1'b1;
            default: credit_used <= credit_used;
         endcase
      end
   end

   assign q.data  = mem[rd_ptr];
   assign q.empty = (count == '0);

   // credit accounting has to keep returning reads out of a full queue
   a_no_write_full: assert property (@(posedge dvi_clk) disable iff (rst)
      wr_en |-> (count != q_cnt_w'(queue_depth)));

endmodule

// ==== hw/sync_gen.sv ====
module sync_gen import dvi_pkg::*; (
   input  logic dvi_clk,
   input  logic rst,
   raster_if.src rs
);

   //////////////////////////////
   // raster counters
   //////////////////////////////

   logic [h_cnt_w-1:0] h_cnt;
   logic [v_cnt_w-1:0] v_cnt;
   logic               h_last;
   logic               v_last;

   // end of line and end of frame
   assign h_last = (h_cnt == h_cnt_w'(h_total - 1));
   assign v_last = (v_cnt == v_cnt_w'(v_total - 1));

   // free running, never stalls
   // reset parks the raster at the start of the front porch,
   // so the fetcher gets the porch and sync lines as lead time
   always_ff @(posedge dvi_clk or posedge rst) begin
      if (rst) begin
         h_cnt <= '0;
         v_cnt <= v_cnt_w'(v_active);
      end else begin
         if (h_last) begin
            h_cnt <= '0;
            // next line, wrap at frame end
            if (v_last) begin
               v_cnt <= '0;
            end else begin
               v_cnt <= v_cnt + 1'b1;
            end
         end else begin
            h_cnt <= h_cnt + 1'b1;
         end
      end
   end

   //////////////////////////////
   // position decode
   //////////////////////////////

   logic h_vis;
   logic v_vis;

   // visible column and row
   assign h_vis = (h_cnt < h_cnt_w'(h_active));
   assign v_vis = (v_cnt < v_cnt_w'(v_active));

   // hsync window after the front porch
   assign rs.hsync = (h_cnt >= h_cnt_w'(h_active + h_front)) &&
                     (h_cnt <  h_cnt_w'(h_active + h_front + h_sync));

   // vsync lines after the vertical front porch
   assign rs.vsync = (v_cnt >= v_cnt_w'(v_active + v_front)) &&
                     (v_cnt <  v_cnt_w'(v_active + v_front + v_sync));

   // visible area
   assign rs.active = h_vis && v_vis;

   // first visible pixel of the frame
   assign rs.frame_start = (h_cnt == '0) && (v_cnt == '0);

endmodule

// ==== test/tb_checker.sv ====
module tb_checker import dvi_pkg::*; (
   input  logic             dvi_clk,
   input  logic             rst,
   // DUT pixel port
   input  logic [pix_w-1:0] d,
   input  logic             hsync,
   input  logic             vsync,
   input  logic             blank,
   input  logic             underflow,
   // frame buffer contents as loaded by the testbench
   input  logic [pix_w-1:0] fb [fb_words],
   // end of test strobe and its number
   input  logic             test_end,
   input  int               test_num,
   output int               error_total,
   output int               check_total,
   output int               tests_reported
);

   timeunit 1ns;
   timeprecision 100ps;

   // reference raster position shown on the outputs
   int   h_pos;
   int   v_pos;
   // next frame-buffer word expected on d
   int   word_idx;
   // high once the first edge after reset release has passed
   logic started;
   // per test counts
   int   test_checks;
   int   test_errors;

   initial begin
      h_pos          = 0;
      v_pos          = v_active;
      word_idx       = 0;
      started        = 1'b0;
      test_checks    = 0;
      test_errors    = 0;
      error_total    = 0;
      check_total    = 0;
      tests_reported = 0;
   end

   //////////////////////////////
   // compare helpers
   //////////////////////////////

   task automatic compare_signal(input string name, input logic [pix_w-1:0] expected,
                                 input logic [pix_w-1:0] actual);
      test_checks++;
      check_total++;
      // x or z counts as wrong
      if (actual !== expected) begin
         test_errors++;
         error_total++;
         $display("mismatch at %0d ns: %s expected %0h got %0h",
                  $time, name, expected, actual);
      end
   endtask

   // reset values of the pixel port
   task automatic check_reset_state();
      compare_signal("hsync", 1'b0, hsync);
      compare_signal("vsync", 1'b0, vsync);
      compare_signal("blank", 1'b1, blank);
      compare_signal("d", '0, d);
      compare_signal("underflow", 1'b0, underflow);
   endtask

   // expected outputs for the current model position
   task automatic check_position();
      logic             act;
      logic             exp_hs;
      logic             exp_vs;
      logic [pix_w-1:0] exp_d;
      act    = (h_pos < h_active) && (v_pos < v_active);
      exp_hs = (h_pos >= h_active + h_front) && (h_pos < h_active + h_front + h_sync);
      exp_vs = (v_pos >= v_active + v_front) && (v_pos < v_active + v_front + v_sync);
      // blanked pixels carry zero
      exp_d  = act ? fb[word_idx] : '0;
      compare_signal("hsync", exp_hs, hsync);
      compare_signal("vsync", exp_vs, vsync);
      compare_signal("blank", !act, blank);
      compare_signal("d", exp_d, d);
      // lead time covers the queue fill
      compare_signal("underflow", 1'b0, underflow);
   endtask

   //////////////////////////////
   // raster model
   //////////////////////////////

   task automatic advance_position();
      // word index moves past each visible pixel
      if ((h_pos < h_active) && (v_pos < v_active)) begin
         word_idx = (word_idx + 1) % fb_words;
      end
      if (h_pos == h_total - 1) begin
         h_pos = 0;
         v_pos = (v_pos == v_total - 1) ? 0 : v_pos + 1;
      end else begin
         h_pos++;
      end
   endtask

   task automatic report_test();
      $display("test %0d done: %0d checks, %0d errors", test_num + 1, test_checks, test_errors);
      tests_reported++;
      test_checks = 0;
      test_errors = 0;
   endtask

   // rst only moves 2 ns after the edge, stable here
   always @(posedge dvi_clk) begin
      if (rst) begin
         // first output cycle shows the front porch start
         started  = 1'b0;
         h_pos    = 0;
         v_pos    = v_active;
         word_idx = 0;
      end else if (!started) begin
         started = 1'b1;
      end else begin
         advance_position();
      end
      if (test_end) report_test();
   end

   // outputs are registered, mid cycle is quiet
   always @(negedge dvi_clk) begin
      if (rst || !started) begin
         check_reset_state();
      end else begin
         check_position();
      end
   end

endmodule

// ==== test/tb_clock_gen.sv ====
module tb_clock_gen #(
   // full period in ns
   parameter int period_ns = 40
) (
   output logic clk
);

   timeunit 1ns;
   timeprecision 100ps;

   // free running, low for the first half period
   initial begin
      clk = 1'b0;
      forever begin
         #(period_ns / 2);
         clk = ~clk;
      end
   end

endmodule

// ==== test/tb_dvi_top.sv ====
module tb_dvi_top import dvi_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int num_tests       = 3;
   localparam int frames_per_test = 3;
   localparam int frame_cycles    = h_total * v_total;
   localparam int reset_cycles    = 5;
   // input drive offset after the rising edge, ns
   localparam int drive_ns        = 2;
   // full run length with slack per test for reset and reporting
   localparam int cycle_limit     = num_tests * (frames_per_test * frame_cycles + 40);

   logic                 dvi_clk;
   logic                 rst;
   logic [fb_addr_w-1:0] rom_addr;
   logic [pix_w-1:0]     rom_data;
   logic [pix_w-1:0]     d;
   logic                 hsync;
   logic                 vsync;
   logic                 blank;
   logic                 underflow;

   // frame buffer model
   logic [pix_w-1:0]     fb [fb_words];
   logic [31:0]          lcg_state;
   // test sequencing towards the checker
   logic                 test_end;
   int                   test_num;
   int                   error_total;
   int                   check_total;
   int                   tests_reported;

   //////////////////////////////
   // clock, DUT, checker
   //////////////////////////////

   tb_clock_gen #(.period_ns(40)) clock_inst (.clk(dvi_clk));

   dvi_top dvi_top_inst (
      .dvi_clk   (dvi_clk),
      .rst       (rst),
      .rom_addr  (rom_addr),
      .rom_data  (rom_data),
      .d         (d),
      .hsync     (hsync),
      .vsync     (vsync),
      .blank     (blank),
      .underflow (underflow)
   );

   tb_checker check_inst (
      .dvi_clk        (dvi_clk),
      .rst            (rst),
      .d              (d),
      .hsync          (hsync),
      .vsync          (vsync),
      .blank          (blank),
      .underflow      (underflow),
      .fb             (fb),
      .test_end       (test_end),
      .test_num       (test_num),
      .error_total    (error_total),
      .check_total    (check_total),
      .tests_reported (tests_reported)
   );

   // read port, fixed one cycle latency
   always @(posedge dvi_clk) begin
      rom_data <= fb[rom_addr];
   end

   //////////////////////////////
   // stimulus helpers
   //////////////////////////////

   // numerical recipes constants
   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // new contents, only called while rst is high
   task automatic fill_frame_buffer();
      for (int i = 0; i < fb_words; i++) begin
         lcg_state = lcg_next(lcg_state);
         fb[i]     = lcg_state[31:8];
      end
   endtask

   // n rising edges, then the drive offset
   task automatic step(input int n);
      repeat (n) @(posedge dvi_clk);
      #(drive_ns);
   endtask

   //////////////////////////////
   // test list
   //////////////////////////////

   initial begin
      int unsigned gap;
      rst       = 1'b1;
      rom_data  = '0;
      test_end  = 1'b0;
      test_num  = 0;
      lcg_state = 32'hb31b;
      fill_frame_buffer();
      for (int t = 0; t < num_tests; t++) begin
         if (t > 0) begin
            // lands somewhere inside the previous test's last frame
            rst = 1'b1;
            fill_frame_buffer();
         end
         step(reset_cycles);
         rst      = 1'b0;
         test_num = t;
         if (t == num_tests - 1) begin
            step(frames_per_test * frame_cycles);
         end else begin
            lcg_state = lcg_next(lcg_state);
            gap       = lcg_state[31:16] % frame_cycles;
            step((frames_per_test - 1) * frame_cycles + gap);
         end
         test_end = 1'b1;
         step(1);
         test_end = 1'b0;
      end
      step(2);
      $display("%0d tests, %0d checks, %0d errors", tests_reported, check_total, error_total);
      if ((error_total == 0) && (tests_reported == num_tests)) begin
         $display("Finished with no errors");
      end else begin
         if (tests_reported != num_tests) begin
            $display("only %0d of %0d tests reported", tests_reported, num_tests);
         end
         $display("Finished with errors");
      end
      $finish;
   end

   // watchdog
   initial begin
      int cycles;
      cycles = 0;
      while (cycles < cycle_limit) begin
         @(posedge dvi_clk);
         cycles++;
      end
      $display("run stopped at the cycle limit of %0d before the test list completed", cycles);
      $display("Finished with errors");
      $finish;
   end

endmodule
